// File: tb.f
+incdir+tests
logic/fcvtPkg.sv
logic/cvtReqSide.sv
logic/dblToLong.sv
logic/cvtRspSide.sv
logic/fcvtTop.sv
tests/fcvtTb.sv

// File: tests/fcvtRefModel.svh
// Included inside the testbench module, which must declare errCount, testCount and failCount first
`ifndef FCVT_REF_MODEL_SVH
`define FCVT_REF_MODEL_SVH

// Truncate toward zero, saturate out of range, sign-extend 32-bit words
function automatic fcvtPkg::cvtRes_t refConvert(input fcvtPkg::dbl_t d, input logic sgnd,
                                                input logic w32, input fcvtPkg::tag_t tag);
    fcvtPkg::cvtRes_t r;
    int               e;
    int               width;
    logic [127:0]     mag;
    logic             fits;
    logic [63:0]      val;
    logic [63:0]      hi;
    logic [63:0]      lo;
    r     = '0;
    r.tag = tag;
    e     = int'(d[62:52]) - 1023;     // Unbiased exponent
    width = w32 ? 32 : 64;
    hi    = sgnd ? (64'd1 << (width - 1)) - 64'd1 : '1;  // Unsigned 32 max sign-extends to ones
    lo    = sgnd ? ~hi : '0;
    if (d[62:0] == '0) return r;       // Plus or minus zero
    if (e < 0) begin
        r.underflow = 1'b1;
        return r;
    end
    fits = 1'b0;
    if (e <= 64 && d[62:52] != 11'h7FF) begin
        mag = ({75'd0, 1'b1, d[51:0]} << e) >> 52;
        if (!sgnd)      fits = !d[63] && (mag < (128'd1 << width));
        else if (d[63]) fits = (mag <= (128'd1 << (width - 1)));
        else            fits = (mag < (128'd1 << (width - 1)));
    end
    if (!fits) begin
        r.overflow = 1'b1;
        // NaN saturates high whatever its sign
        r.result   = (d[63] && !(d[62:52] == 11'h7FF && d[51:0] != '0)) ? lo : hi;
        return r;
    end
    val      = d[63] ? -mag[63:0] : mag[63:0];
    r.result = w32 ? {{32{val[31]}}, val[31:0]} : val;
    return r;
endfunction

// Galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic checkRes(input fcvtPkg::cvtRes_t exp, input fcvtPkg::cvtRes_t got);
    if (got.tag !== exp.tag) begin
        $display("ERR o_rsp.tag: expected %h, got %h", exp.tag, got.tag);
        errCount++;
    end
    if (got.result !== exp.result) begin
        $display("ERR o_rsp.result (tag %h): expected %h, got %h", exp.tag, exp.result, got.result);
        errCount++;
    end
    if (got.overflow !== exp.overflow) begin
        $display("ERR o_rsp.overflow (tag %h): expected %h, got %h",
                 exp.tag, exp.overflow, got.overflow);
        errCount++;
    end
    if (got.underflow !== exp.underflow) begin
        $display("ERR o_rsp.underflow (tag %h): expected %h, got %h",
                 exp.tag, exp.underflow, got.underflow);
        errCount++;
    end
endtask

task automatic reportTest(input string name, input int errBefore);
    testCount++;
    if (errCount != errBefore) failCount++;
    $display("%-14s %s, %0d errors", name,
             (errCount == errBefore) ? "passed" : "FAILED", errCount - errBefore);
endtask

`endif

// File: tests/fcvtTb.sv
// Runs fcvtTop at RSP_DEPTH 4 only; all handshakes are driven and sampled 10 ns after the rising edge
`timescale 1ns/1ns
`default_nettype none

module fcvtTb;

    localparam int RSP_DEPTH   = 4;
    localparam int HS_LIMIT    = 50;        // Cycles allowed per handshake phase
    localparam int TEST_OPS    = 23 + 8 + 8 + 5 + 200;
    localparam int WATCHDOG_NS = TEST_OPS * 200 * 100;

    logic             clk;
    logic             nrst;
    logic             req;
    fcvtPkg::cvtOp_t  op;
    logic             ack;
    logic             rspReq;
    fcvtPkg::cvtRes_t rsp;
    logic             rspAck;

    int               errCount;
    int               testCount;
    int               failCount;
    fcvtPkg::tag_t    nextTag;
    logic [31:0]      lfsrState;

    `include "fcvtRefModel.svh"

    fcvtTop #(
        .RSP_DEPTH(RSP_DEPTH)
    ) fcvtTop_inst (
        .i_clk    (clk),
        .i_nrst   (nrst),
        .i_req    (req),
        .i_op     (op),
        .o_ack    (ack),
        .o_rspReq (rspReq),
        .o_rsp    (rsp),
        .i_rspAck (rspAck)
    );

    always #50 clk = ~clk;

    task automatic nextCycle();
        @(posedge clk);
        #10;
    endtask

    // One LFSR step per bit
    task automatic randBits(input int n, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v         = {v[62:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
    endtask

    task automatic sendReq(input fcvtPkg::cvtOp_t o);
        int n;
        op  = o;
        req = 1'b1;
        n   = 0;
        while (!ack && n < HS_LIMIT) begin
            nextCycle();
            n++;
        end
        if (!ack) begin
            $display("Request with tag %h was never acknowledged", o.tag);
            errCount++;
        end
        req = 1'b0;
        n   = 0;
        while (ack && n < HS_LIMIT) begin
            nextCycle();
            n++;
        end
        if (ack) begin
            $display("Acknowledge for tag %h stayed high after the request dropped", o.tag);
            errCount++;
        end
    endtask

    task automatic takeRsp(output fcvtPkg::cvtRes_t r);
        int n;
        r = '0;
        n = 0;
        while (!rspReq && n < HS_LIMIT) begin
            nextCycle();
            n++;
        end
        if (!rspReq) begin
            $display("No response arrived within %0d cycles", HS_LIMIT);
            errCount++;
            return;
        end
        r      = rsp;
        rspAck = 1'b1;
        n      = 0;
        while (rspReq && n < HS_LIMIT) begin
            nextCycle();
            n++;
        end
        if (rspReq) begin
            $display("Response request stayed high after it was acknowledged");
            errCount++;
        end
        rspAck = 1'b0;
    endtask

    task automatic exchange(input fcvtPkg::dbl_t d, input logic s, input logic w,
                            input fcvtPkg::cvtRes_t exp);
        fcvtPkg::cvtOp_t  o;
        fcvtPkg::cvtRes_t got;
        o.operand  = d;
        o.isSigned = s;
        o.w32      = w;
        o.tag      = exp.tag;
        sendReq(o);
        takeRsp(got);
        checkRes(exp, got);
        nextTag++;
    endtask

    task automatic convertCheck(input fcvtPkg::dbl_t d, input logic s, input logic w);
        exchange(d, s, w, refConvert(d, s, w, nextTag));
    endtask

    task automatic convertExpect(input fcvtPkg::dbl_t d, input logic s, input logic w,
                                 input fcvtPkg::xlen_t r, input logic ovf, input logic unf);
        fcvtPkg::cvtRes_t exp;
        exp.result    = r;
        exp.overflow  = ovf;
        exp.underflow = unf;
        exp.tag       = nextTag;
        exchange(d, s, w, exp);
    endtask

    task automatic exactInts();
        fcvtPkg::dbl_t vals [5];
        int            start;
        start   = errCount;
        vals[0] = $realtobits(0.0);
        vals[1] = $realtobits(1.0);
        vals[2] = $realtobits(-1.0);
        vals[3] = $realtobits(1099511627776.0);    // 2^40
        vals[4] = $realtobits(-2147483648.0);      // -2^31
        foreach (vals[i]) begin
            for (int m = 0; m < 4; m++) begin
                convertCheck(vals[i], m[1], m[0]);
            end
        end
        convertExpect(vals[2], 1'b1, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b0, 1'b0);
        convertExpect(vals[3], 1'b1, 1'b0, 64'h0000_0100_0000_0000, 1'b0, 1'b0);
        convertExpect(vals[4], 1'b1, 1'b1, 64'hFFFF_FFFF_8000_0000, 1'b0, 1'b0);
        reportTest("exactInts", start);
    endtask

    task automatic fractions();
        int start;
        start = errCount;
        convertExpect($realtobits(2.75), 1'b1, 1'b0, 64'd2, 1'b0, 1'b0);
        convertExpect($realtobits(2.75), 1'b0, 1'b1, 64'd2, 1'b0, 1'b0);
        convertExpect($realtobits(-2.75), 1'b1, 1'b0, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b0);
        convertExpect($realtobits(-2.75), 1'b1, 1'b1, 64'hFFFF_FFFF_FFFF_FFFE, 1'b0, 1'b0);
        convertExpect($realtobits(0.25), 1'b0, 1'b0, 64'd0, 1'b0, 1'b1);
        convertExpect($realtobits(-0.5), 1'b1, 1'b0, 64'd0, 1'b0, 1'b1);
        convertExpect(64'h0000_0000_0000_0001, 1'b1, 1'b1, 64'd0, 1'b0, 1'b1);  // Subnormal
        convertExpect(64'h8000_0000_0000_0000, 1'b1, 1'b0, 64'd0, 1'b0, 1'b0);  // Minus zero
        reportTest("fractions", start);
    endtask

    task automatic overflows();
        int start;
        start = errCount;
        convertExpect($realtobits(9223372036854775808.0), 1'b1, 1'b0,
                      64'h7FFF_FFFF_FFFF_FFFF, 1'b1, 1'b0);
        convertExpect($realtobits(4294967296.0), 1'b0, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b0);
        convertExpect($realtobits(-3.0), 1'b0, 1'b0, 64'd0, 1'b1, 1'b0);
        convertExpect($realtobits(-3.0), 1'b0, 1'b1, 64'd0, 1'b1, 1'b0);
        convertExpect(64'h7FF0_0000_0000_0000, 1'b1, 1'b1, 64'h0000_0000_7FFF_FFFF, 1'b1, 1'b0);
        convertExpect(64'hFFF0_0000_0000_0000, 1'b1, 1'b0, 64'h8000_0000_0000_0000, 1'b1, 1'b0);
        convertExpect(64'hFFF8_0000_0000_0000, 1'b0, 1'b1, 64'hFFFF_FFFF_FFFF_FFFF, 1'b1, 1'b0);
        convertExpect(64'h7FF8_0000_0000_0001, 1'b1, 1'b0, 64'h7FFF_FFFF_FFFF_FFFF, 1'b1, 1'b0);
        reportTest("overflows", start);
    endtask

    task automatic backPressure();
        fcvtPkg::cvtRes_t expQ [$];
        fcvtPkg::cvtRes_t got;
        fcvtPkg::cvtOp_t  o;
        int               start;
        logic             sawAck;
        start  = errCount;
        sawAck = 1'b0;
        for (int i = 0; i <= RSP_DEPTH; i++) begin
            o.operand  = $realtobits(10.5 * (i + 1) - 40.0);
            o.isSigned = 1'b1;
            o.w32      = i[0];
            o.tag      = nextTag;
            expQ.push_back(refConvert(o.operand, o.isSigned, o.w32, o.tag));
            nextTag++;
            if (i < RSP_DEPTH) sendReq(o);
        end
        op  = o;        // Every result slot is now taken
        req = 1'b1;
        repeat (20) begin
            nextCycle();
            sawAck |= ack;
        end
        if (sawAck) begin
            $display("Request acknowledged although all %0d result slots were taken", RSP_DEPTH);
            errCount++;
        end
        req = 1'b0;
        repeat (RSP_DEPTH) begin
            takeRsp(got);
            checkRes(expQ.pop_front(), got);
        end
        sendReq(o);
        takeRsp(got);
        checkRes(expQ.pop_front(), got);
        reportTest("backPressure", start);
    endtask

    task automatic randomOps();
        fcvtPkg::cvtRes_t expQ [$];
        int               start;
        start = errCount;
        fork
            begin
                fcvtPkg::cvtOp_t o;
                logic [63:0]     b;
                int              span;
                repeat (200) begin
                    randBits(2, b);
                    o.isSigned = b[1];
                    o.w32      = b[0];
                    span       = o.w32 ? (o.isSigned ? 31 : 32) : (o.isSigned ? 63 : 64);
                    randBits(7, b);
                    o.operand[62:52] = 11'(1023 + b[6:0] % span);   // Keeps the value in range
                    randBits(1, b);
                    o.operand[63] = b[0] & o.isSigned;
                    randBits(52, b);
                    o.operand[51:0] = b[51:0];
                    o.tag = nextTag;
                    expQ.push_back(refConvert(o.operand, o.isSigned, o.w32, o.tag));
                    nextTag++;
                    sendReq(o);
                end
            end
            begin
                fcvtPkg::cvtRes_t got;
                repeat (200) begin
                    takeRsp(got);
                    if (expQ.size() == 0) begin
                        $display("Response with tag %h arrived with no request outstanding",
                                 got.tag);
                        errCount++;
                    end else begin
                        checkRes(expQ.pop_front(), got);
                    end
                end
            end
        join
        reportTest("randomOps", start);
    endtask

    initial begin
        clk       = 1'b0;
        nrst      = 1'b0;
        req       = 1'b0;
        op        = '0;
        rspAck    = 1'b0;
        errCount  = 0;
        testCount = 0;
        failCount = 0;
        nextTag   = '0;
        lfsrState = 32'hc622_2d99;
        repeat (16) @(posedge clk);
        #10;
        nrst = 1'b1;
        nextCycle();
        exactInts();
        fractions();
        overflows();
        backPressure();
        randomOps();
        $display("%0d tests, %0d failed, %0d errors", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // Bounded by the summed test lengths
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/fcvtTop.sv
// RSP_DEPTH must be 4 or more; results return in request order, at least 4 cycles after o_ack
`timescale 1ns/1ns
`default_nettype none

module fcvtTop #(
    parameter int RSP_DEPTH = 4    // Result slots and credit limit
) (
    input  wire logic            i_clk,
    input  wire logic            i_nrst,
    input  wire logic            i_req,
    input  wire fcvtPkg::cvtOp_t i_op,
    output logic                 o_ack,
    output logic                 o_rspReq,
    output fcvtPkg::cvtRes_t     o_rsp,
    input  wire logic            i_rspAck
);

    logic              issueValid;
    fcvtPkg::cvtOp_t   issueOp;
    logic              resValid;
    fcvtPkg::cvtRes_t  resData;
    logic              creditReturn;   // One per completed response handshake

    cvtReqSide #(
        .RSP_DEPTH(RSP_DEPTH)
    ) cvtReqSide_inst (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_req          (i_req),
        .i_op           (i_op),
        .o_ack          (o_ack),
        .o_issueValid   (issueValid),
        .o_issueOp      (issueOp),
        .i_creditReturn (creditReturn)
    );

    dblToLong dblToLong_inst (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_issueValid (issueValid),
        .i_issueOp    (issueOp),
        .o_resValid   (resValid),
        .o_resData    (resData)
    );

    cvtRspSide #(
        .RSP_DEPTH(RSP_DEPTH)
    ) cvtRspSide_inst (
        .i_clk          (i_clk),
        .i_nrst         (i_nrst),
        .i_resValid     (resValid),
        .i_resData      (resData),
        .o_rspReq       (o_rspReq),
        .o_rsp          (o_rsp),
        .i_rspAck       (i_rspAck),
        .o_creditReturn (creditReturn)
    );

endmodule

`default_nettype wire

// File: logic/cvtRspSide.sv
// Never stalls the pipeline; the requester side credits must keep pushes below RSP_DEPTH
`timescale 1ns/1ns
`default_nettype none

module cvtRspSide #(
    parameter int RSP_DEPTH = 4
) (
    input  wire logic             i_clk,
    input  wire logic             i_nrst,
    input  wire logic             i_resValid,
    input  wire fcvtPkg::cvtRes_t i_resData,
    output logic                  o_rspReq,
    output fcvtPkg::cvtRes_t      o_rsp,
    input  wire logic             i_rspAck,
    output logic                  o_creditReturn
);

    localparam int PW = $clog2(RSP_DEPTH);
    localparam int CW = $clog2(RSP_DEPTH + 1);
    localparam logic [PW-1:0] LAST_SLOT = PW'(RSP_DEPTH - 1);
    localparam logic [CW-1:0] FULL_CNT  = CW'(RSP_DEPTH);

    typedef enum logic [1:0] {IDLE, REQ, WAIT_ACK_LOW} rspState_t;

    rspState_t         state;
    fcvtPkg::cvtRes_t  fifoMem [RSP_DEPTH];
    logic [PW-1:0]     wrPtr;
    logic [PW-1:0]     rdPtr;
    logic [CW-1:0]     fill;
    logic              pop;

    assign pop      = (state == REQ) && i_rspAck;
    assign o_rspReq = (state == REQ);
    assign o_rsp    = fifoMem[rdPtr];  // Head stays put until the pop

    always_ff @(posedge i_clk) begin
        if (i_resValid) fifoMem[wrPtr] <= i_resData;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (i_resValid) wrPtr <= (wrPtr == LAST_SLOT) ? '0 : wrPtr + 1'b1;
            if (pop)        rdPtr <= (rdPtr == LAST_SLOT) ? '0 : rdPtr + 1'b1;
            if (i_resValid && !pop)      fill <= fill + 1'b1;
            else if (!i_resValid && pop) fill <= fill - 1'b1;
        end
    end

    // Four-phase sender
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state          <= IDLE;
            o_creditReturn <= 1'b0;
        end else begin
            o_creditReturn <= pop;
            case (state)
                IDLE:         if (fill != '0) state <= REQ;
                REQ:          if (i_rspAck) state <= WAIT_ACK_LOW;
                WAIT_ACK_LOW: if (!i_rspAck) state <= IDLE;
                default:      state <= IDLE;
            endcase
        end
    end

    noPushFull: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_resValid |-> (fill != FULL_CNT));

endmodule

`default_nettype wire

// File: logic/dblToLong.sv
// Truncates toward zero; subnormals only count as nonzero magnitudes below 1, no stall input
`timescale 1ns/1ns
`default_nettype none

module dblToLong (
    input  wire logic            i_clk,
    input  wire logic            i_nrst,
    input  wire logic            i_issueValid,
    input  wire fcvtPkg::cvtOp_t i_issueOp,
    output logic                 o_resValid,
    output fcvtPkg::cvtRes_t     o_resData
);

    localparam fcvtPkg::expo_t EXP_ONE = fcvtPkg::expo_t'(fcvtPkg::EXP_BIAS);

    // Unpacked operand
    typedef struct packed {
        logic            sign;
        fcvtPkg::expo_t  expo;
        fcvtPkg::mant_t  mant;
        logic            isSigned;
        logic            w32;
        fcvtPkg::tag_t   tag;
    } stage1_t;

    // Range checked, magnitude aligned
    typedef struct packed {
        logic            sign;
        logic            isSigned;
        logic            w32;
        logic            isNan;
        logic            overflow;
        logic            underflow;
        fcvtPkg::xlen_t  mag;
        fcvtPkg::tag_t   tag;
    } stage2_t;

    logic [fcvtPkg::CVT_LATENCY-1:0] vld;
    stage1_t           s1;
    stage2_t           s2;
    stage2_t           s2Next;
    fcvtPkg::cvtRes_t  resNext;

    fcvtPkg::expo_t    expMax;      // Largest exponent that still fits
    logic              fracZero;
    logic              tooBig;
    logic              negEdge;
    logic [5:0]        shiftAmt;
    fcvtPkg::xlen_t    mantPre;
    fcvtPkg::xlen_t    signedVal;
    fcvtPkg::xlen_t    satVal;
    logic              satNeg;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            vld <= '0;
        end else begin
            vld <= {vld[fcvtPkg::CVT_LATENCY-2:0], i_issueValid};
        end
    end

    assign o_resValid = vld[fcvtPkg::CVT_LATENCY-1];

    // Stage 1
    always_ff @(posedge i_clk) begin
        if (i_issueValid) begin
            s1.sign     <= i_issueOp.operand[63];
            s1.expo     <= i_issueOp.operand[62:52];
            s1.mant     <= {|i_issueOp.operand[62:52], i_issueOp.operand[51:0]};  // Hidden bit
            s1.isSigned <= i_issueOp.isSigned;
            s1.w32      <= i_issueOp.w32;
            s1.tag      <= i_issueOp.tag;
        end
    end

    // Stage 2
    always_comb begin
        if (s1.w32) begin
            expMax = EXP_ONE + (s1.isSigned ? 11'd30 : 11'd31);
        end else begin
            expMax = EXP_ONE + (s1.isSigned ? 11'd62 : 11'd63);
        end

        fracZero = (s1.mant[51:0] == '0);
        tooBig   = (s1.expo > expMax);
        // -2^31 and -2^63 lie one exponent step past the positive limit
        negEdge  = s1.sign && s1.isSigned && (s1.expo == expMax + 11'd1) && fracZero;
        shiftAmt = 6'(EXP_ONE + 11'd63 - s1.expo);
        mantPre  = {s1.mant, 11'd0};

        s2Next.sign      = s1.sign;
        s2Next.isSigned  = s1.isSigned;
        s2Next.w32       = s1.w32;
        s2Next.isNan     = (s1.expo == '1) && !fracZero;
        s2Next.overflow  = 1'b0;
        s2Next.underflow = 1'b0;
        s2Next.mag       = '0;
        s2Next.tag       = s1.tag;

        if (s1.expo < EXP_ONE) begin
            s2Next.underflow = (s1.expo != '0) || !fracZero;   // Zero itself is exact
        end else if ((tooBig && !negEdge) || (s1.sign && !s1.isSigned)) begin
            s2Next.overflow = 1'b1;     // Also infinity and NaN
        end else begin
            s2Next.mag = mantPre >> shiftAmt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (vld[0]) s2 <= s2Next;
    end

    // Stage 3
    always_comb begin
        signedVal = s2.sign ? (~s2.mag) + 64'd1 : s2.mag;
        satNeg    = s2.sign && !s2.isNan;  // NaN goes to the top of the range

        if (s2.w32) begin
            if (s2.isSigned) satVal = satNeg ? fcvtPkg::INT32_MIN_SX : fcvtPkg::INT32_MAX_SX;
            else             satVal = satNeg ? '0 : fcvtPkg::UINT32_MAX_SX;
        end else begin
            if (s2.isSigned) satVal = satNeg ? fcvtPkg::INT64_MIN : fcvtPkg::INT64_MAX;
            else             satVal = satNeg ? '0 : fcvtPkg::UINT64_MAX;
        end

        if (s2.overflow) begin
            resNext.result = satVal;
        end else if (s2.w32) begin
            resNext.result = {{32{signedVal[31]}}, signedVal[31:0]};
        end else begin
            resNext.result = signedVal;     // Underflow already carries a zero magnitude
        end
        resNext.overflow  = s2.overflow;
        resNext.underflow = s2.underflow;
        resNext.tag       = s2.tag;
    end

    always_ff @(posedge i_clk) begin
        if (vld[1]) o_resData <= resNext;
    end

    // The tag must ride along with the valid bit through every stage
    fixedLatency: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_issueValid |-> ##(fcvtPkg::CVT_LATENCY) (o_resValid &&
            o_resData.tag == $past(i_issueOp.tag, fcvtPkg::CVT_LATENCY)));

    underflowZero: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_resValid && o_resData.underflow |-> !o_resData.overflow && o_resData.result == '0);

endmodule

`default_nettype wire

// File: logic/cvtReqSide.sv
// Requester must keep i_op stable while i_req is high and raise i_req again only after o_ack is low
`timescale 1ns/1ns
`default_nettype none

module cvtReqSide #(
    parameter int RSP_DEPTH = 4
) (
    input  wire logic            i_clk,
    input  wire logic            i_nrst,
    input  wire logic            i_req,
    input  wire fcvtPkg::cvtOp_t i_op,
    output logic                 o_ack,
    output logic                 o_issueValid,
    output fcvtPkg::cvtOp_t      o_issueOp,
    input  wire logic            i_creditReturn
);

    localparam int CW = $clog2(RSP_DEPTH + 1);
    localparam logic [CW-1:0] CREDIT_MAX = CW'(RSP_DEPTH);

    typedef enum logic [1:0] {IDLE, ACKED, WAIT_LOW} reqState_t;

    reqState_t     state;
    logic [CW-1:0] creditCnt;   // Ops in the pipeline or waiting in the result FIFO
    logic          accept;

    // Take a new operand only with a free result slot
    assign accept = (state == IDLE) && i_req && (creditCnt < CREDIT_MAX) && !o_issueValid;
    assign o_ack  = (state != IDLE);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state        <= IDLE;
            o_issueValid <= 1'b0;
        end else begin
            o_issueValid <= accept;     // One-cycle issue pulse
            case (state)
                IDLE:     if (accept) state <= ACKED;
                ACKED:    state <= i_req ? WAIT_LOW : IDLE;
                WAIT_LOW: if (!i_req) state <= IDLE;   // Ack drops with this edge
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) o_issueOp <= i_op;
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            creditCnt <= '0;
        end else if (accept && !i_creditReturn) begin
            creditCnt <= creditCnt + 1'b1;
        end else if (!accept && i_creditReturn) begin
            creditCnt <= creditCnt - 1'b1;
        end
    end

    creditBound: assert property (@(posedge i_clk) disable iff (!i_nrst)
        creditCnt <= CREDIT_MAX);

    // Requester holds the operand while i_req stays high
    opStableDuringReq: assert property (@(posedge i_clk) disable iff (!i_nrst)
        i_req && $past(i_req) |-> $stable(i_op));

endmodule

`default_nettype wire

// File: logic/fcvtPkg.sv
// Doubles only, round toward zero; 32-bit saturation words are stored already sign-extended
`default_nettype none

package fcvtPkg;

    typedef logic [63:0] dbl_t;     // IEEE-754 double
    typedef logic [63:0] xlen_t;    // Integer result word
    typedef logic [10:0] expo_t;    // Biased exponent
    typedef logic [52:0] mant_t;    // Mantissa with hidden bit
    typedef logic [3:0]  tag_t;     // Chosen by the requester, echoed back

    // Request into the unit
    typedef struct packed {
        dbl_t operand;
        logic isSigned;
        logic w32;          // 32-bit target
        tag_t tag;
    } cvtOp_t;

    // Response out of the unit
    typedef struct packed {
        xlen_t result;
        logic  overflow;
        logic  underflow;
        tag_t  tag;
    } cvtRes_t;

    localparam int EXP_BIAS = 1023;

    // Saturation words
    localparam xlen_t INT64_MAX     = 64'h7FFF_FFFF_FFFF_FFFF;
    localparam xlen_t INT64_MIN     = 64'h8000_0000_0000_0000;
    localparam xlen_t UINT64_MAX    = 64'hFFFF_FFFF_FFFF_FFFF;
    localparam xlen_t INT32_MAX_SX  = 64'h0000_0000_7FFF_FFFF;
    localparam xlen_t INT32_MIN_SX  = 64'hFFFF_FFFF_8000_0000;
    localparam xlen_t UINT32_MAX_SX = 64'hFFFF_FFFF_FFFF_FFFF;  // 0xFFFFFFFF with bit 31 copied up

    // Issue to result, in clock cycles
    localparam int CVT_LATENCY = 3;

endpackage

`default_nettype wire
